// File: hw/wisc_pkg.sv
/* Shared types, opcode and function encodings, ALU operations
   and instruction field positions for the 16-bit pipeline */
package wisc_pkg;

   localparam int DATA_W   = 16;
   localparam int NUM_REGS = 8;

   typedef logic [DATA_W-1:0]           data_t;
   typedef logic [$clog2(NUM_REGS)-1:0] reg_idx_t;

   // Major opcode, instruction bits 15:11
   typedef enum logic [4:0] {
      OP_HALT  = 5'b00000,
      OP_NOP   = 5'b00001,
      OP_ADDI  = 5'b01000,
      OP_SUBI  = 5'b01001,
      OP_XORI  = 5'b01010,
      OP_ANDNI = 5'b01011,
      OP_SLBI  = 5'b10010,
      OP_LBI   = 5'b11000,
      OP_RTYPE = 5'b11011
   } opcode_t;

   // Register-register function, bits 1:0
   typedef enum logic [1:0] {
      FN_ADD  = 2'b00,
      FN_SUB  = 2'b01,
      FN_XOR  = 2'b10,
      FN_ANDN = 2'b11
   } rfunc_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_XOR,
      ALU_ANDN,
      ALU_PASS_B,
      ALU_SHIFT_OR
   } alu_op_t;

   // Field positions
   localparam int RS_LSB   = 8;
   localparam int RT_LSB   = 5;
   localparam int RD_R_LSB = 2;
   localparam int RD_I_LSB = 5;

   localparam int IMM5_W = 5;
   localparam int IMM8_W = 8;

endpackage

// File: hw/fetch.sv
/* Instruction intake by valid/ready, halt tracking
   and the fetch-to-decode register */
`timescale 1ns/10ps

module fetch (
   input  logic            clk,
   input  logic            rst,
   input  logic            instr_valid,
   input  wisc_pkg::data_t instr,
   output logic            instr_ready,
   output logic            fd_valid,
   output wisc_pkg::data_t fd_instr
);

   import wisc_pkg::*;

   logic    halt_seen;
   logic    accept;
   opcode_t in_opcode;

   assign in_opcode   = opcode_t'(instr[DATA_W-1 -: $bits(opcode_t)]);
   assign instr_ready = ~halt_seen;
   assign accept      = instr_valid & instr_ready;

   // Stop taking instructions once a HALT has gone in
   always_ff @(posedge clk) begin
      if (rst) begin
         halt_seen <= 1'b0;
         fd_valid  <= 1'b0;
      end else begin
         fd_valid <= accept;
         if (accept && in_opcode == OP_HALT) begin
            halt_seen <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         fd_instr <= instr;
      end
   end

endmodule

// File: hw/reg_file.sv
/* Eight-entry register file, one write port, two read ports
   with write-through bypass */
`timescale 1ns/10ps

module reg_file (
   input  logic               clk,
   input  logic               rst,
   input  wisc_pkg::reg_idx_t rs_idx,
   input  wisc_pkg::reg_idx_t rt_idx,
   input  logic               wr_en,
   input  wisc_pkg::reg_idx_t wr_reg,
   input  wisc_pkg::data_t    wr_data,
   output wisc_pkg::data_t    rs_data,
   output wisc_pkg::data_t    rt_data
);

   import wisc_pkg::*;

   data_t regs [NUM_REGS];

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (wr_en) begin
         regs[wr_reg] <= wr_data;
      end
   end

   // Same-cycle write shows up on the read ports
   assign rs_data = (wr_en && wr_reg == rs_idx) ? wr_data : regs[rs_idx];
   assign rt_data = (wr_en && wr_reg == rt_idx) ? wr_data : regs[rt_idx];

endmodule

// File: hw/decode.sv
/* Instruction decode, operand read, immediate generation, illegal
   opcode detection and the decode-to-execute register */
`timescale 1ns/10ps

module decode (
   input  logic               clk,
   input  logic               rst,
   input  logic               fd_valid,
   input  wisc_pkg::data_t    fd_instr,
   input  wisc_pkg::data_t    rs_data,
   input  wisc_pkg::data_t    rt_data,
   output wisc_pkg::reg_idx_t rs_idx,
   output wisc_pkg::reg_idx_t rt_idx,
   output logic               de_valid,
   output logic               de_writes,
   output logic               de_halt,
   output logic               de_uses_rt,
   output wisc_pkg::reg_idx_t de_rd,
   output wisc_pkg::reg_idx_t de_rs,
   output wisc_pkg::reg_idx_t de_rt,
   output wisc_pkg::alu_op_t  de_op,
   output wisc_pkg::data_t    de_a,
   output wisc_pkg::data_t    de_b,
   output logic               err
);

   import wisc_pkg::*;

   opcode_t  opcode;
   rfunc_t   func;
   data_t    imm5_sext;
   data_t    imm8_sext;
   data_t    imm8_zext;
   logic     legal;
   logic     writes;
   logic     uses_rt;
   reg_idx_t rd;
   alu_op_t  op;
   data_t    b_sel;

   assign opcode = opcode_t'(fd_instr[DATA_W-1 -: $bits(opcode_t)]);
   assign func   = rfunc_t'(fd_instr[$bits(rfunc_t)-1:0]);
   assign rs_idx = fd_instr[RS_LSB +: $bits(reg_idx_t)];
   assign rt_idx = fd_instr[RT_LSB +: $bits(reg_idx_t)];

   assign imm5_sext = {{(DATA_W-IMM5_W){fd_instr[IMM5_W-1]}}, fd_instr[IMM5_W-1:0]};
   assign imm8_sext = {{(DATA_W-IMM8_W){fd_instr[IMM8_W-1]}}, fd_instr[IMM8_W-1:0]};
   assign imm8_zext = {{(DATA_W-IMM8_W){1'b0}}, fd_instr[IMM8_W-1:0]};

   // Immediate form is the default
   always_comb begin
      legal   = 1'b1;
      writes  = 1'b1;
      uses_rt = 1'b0;
      rd      = fd_instr[RD_I_LSB +: $bits(reg_idx_t)];
      op      = ALU_ADD;
      b_sel   = imm5_sext;
      case (opcode)
         OP_HALT, OP_NOP: writes = 1'b0;
         OP_ADDI:  op = ALU_ADD;
         OP_SUBI:  op = ALU_SUB;
         OP_XORI:  op = ALU_XOR;
         OP_ANDNI: op = ALU_ANDN;
         OP_LBI: begin
            rd    = rs_idx;
            op    = ALU_PASS_B;
            b_sel = imm8_sext;
         end
         OP_SLBI: begin
            rd    = rs_idx;
            op    = ALU_SHIFT_OR;
            b_sel = imm8_zext;
         end
         OP_RTYPE: begin
            rd      = fd_instr[RD_R_LSB +: $bits(reg_idx_t)];
            uses_rt = 1'b1;
            b_sel   = rt_data;
            case (func)
               FN_ADD:  op = ALU_ADD;
               FN_SUB:  op = ALU_SUB;
               FN_XOR:  op = ALU_XOR;
               default: op = ALU_ANDN;
            endcase
         end
         default: begin
            legal  = 1'b0;
            writes = 1'b0;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         de_valid  <= 1'b0;
         de_writes <= 1'b0;
         de_halt   <= 1'b0;
         err       <= 1'b0;
      end else begin
         de_valid  <= fd_valid;
         de_writes <= fd_valid & writes;
         de_halt   <= fd_valid & (opcode == OP_HALT);
         // Sticky until reset
         if (fd_valid && !legal) begin
            err <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      de_uses_rt <= uses_rt;
      de_rd      <= rd;
      de_rs      <= rs_idx;
      de_rt      <= rt_idx;
      de_op      <= op;
      de_a       <= rs_data;
      de_b       <= b_sel;
   end

endmodule

// File: hw/execute.sv
/* Operand forwarding, ALU, and the execute-to-write-back register
   that drives commits and register writes */
`timescale 1ns/10ps

module execute (
   input  logic               clk,
   input  logic               rst,
   input  logic               de_valid,
   input  logic               de_writes,
   input  logic               de_halt,
   input  logic               de_uses_rt,
   input  wisc_pkg::reg_idx_t de_rd,
   input  wisc_pkg::reg_idx_t de_rs,
   input  wisc_pkg::reg_idx_t de_rt,
   input  wisc_pkg::alu_op_t  de_op,
   input  wisc_pkg::data_t    de_a,
   input  wisc_pkg::data_t    de_b,
   output logic               commit_valid,
   output wisc_pkg::reg_idx_t commit_reg,
   output wisc_pkg::data_t    commit_data,
   output logic               halted
);

   import wisc_pkg::*;

   logic  fwd_a;
   logic  fwd_b;
   data_t a_op;
   data_t b_op;
   data_t alu_res;

   // Producer one ahead sits in the commit register
   assign fwd_a = commit_valid && (commit_reg == de_rs);
   assign fwd_b = de_uses_rt && commit_valid && (commit_reg == de_rt);
   assign a_op  = fwd_a ? commit_data : de_a;
   assign b_op  = fwd_b ? commit_data : de_b;

   always_comb begin
      case (de_op)
         ALU_ADD:      alu_res = a_op + b_op;
         ALU_SUB:      alu_res = b_op - a_op;
         ALU_XOR:      alu_res = a_op ^ b_op;
         ALU_ANDN:     alu_res = a_op & ~b_op;
         ALU_SHIFT_OR: alu_res = (a_op << IMM8_W) | b_op;
         default:      alu_res = b_op;
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         commit_valid <= 1'b0;
         halted       <= 1'b0;
      end else begin
         commit_valid <= de_valid & de_writes;
         if (de_valid && de_halt) begin
            halted <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      commit_reg  <= de_rd;
      commit_data <= alu_res;
   end

endmodule

// File: hw/wisc_core.sv
/* Top level of the four-stage pipeline, stage wiring
   and error collection */
`timescale 1ns/10ps

module wisc_core (
   input  logic               clk,
   input  logic               rst,
   input  logic               instr_valid,
   input  wisc_pkg::data_t    instr,
   output logic               instr_ready,
   output logic               commit_valid,
   output wisc_pkg::reg_idx_t commit_reg,
   output wisc_pkg::data_t    commit_data,
   output logic               halted,
   output logic               err
);

   import wisc_pkg::*;

   logic     fd_valid;
   data_t    fd_instr;
   reg_idx_t rs_idx;
   reg_idx_t rt_idx;
   data_t    rs_data;
   data_t    rt_data;
   logic     de_valid;
   logic     de_writes;
   logic     de_halt;
   logic     de_uses_rt;
   reg_idx_t de_rd;
   reg_idx_t de_rs;
   reg_idx_t de_rt;
   alu_op_t  de_op;
   data_t    de_a;
   data_t    de_b;
   logic     decode_err;

   // Decode is the only stage that can flag an error
   assign err = decode_err;

   fetch fetch_i (
      .clk         (clk),
      .rst         (rst),
      .instr_valid (instr_valid),
      .instr       (instr),
      .instr_ready (instr_ready),
      .fd_valid    (fd_valid),
      .fd_instr    (fd_instr)
   );

   decode decode_i (
      .clk        (clk),
      .rst        (rst),
      .fd_valid   (fd_valid),
      .fd_instr   (fd_instr),
      .rs_data    (rs_data),
      .rt_data    (rt_data),
      .rs_idx     (rs_idx),
      .rt_idx     (rt_idx),
      .de_valid   (de_valid),
      .de_writes  (de_writes),
      .de_halt    (de_halt),
      .de_uses_rt (de_uses_rt),
      .de_rd      (de_rd),
      .de_rs      (de_rs),
      .de_rt      (de_rt),
      .de_op      (de_op),
      .de_a       (de_a),
      .de_b       (de_b),
      .err        (decode_err)
   );

   // Commit port doubles as the write port
   reg_file reg_file_i (
      .clk     (clk),
      .rst     (rst),
      .rs_idx  (rs_idx),
      .rt_idx  (rt_idx),
      .wr_en   (commit_valid),
      .wr_reg  (commit_reg),
      .wr_data (commit_data),
      .rs_data (rs_data),
      .rt_data (rt_data)
   );

   execute execute_i (
      .clk          (clk),
      .rst          (rst),
      .de_valid     (de_valid),
      .de_writes    (de_writes),
      .de_halt      (de_halt),
      .de_uses_rt   (de_uses_rt),
      .de_rd        (de_rd),
      .de_rs        (de_rs),
      .de_rt        (de_rt),
      .de_op        (de_op),
      .de_a         (de_a),
      .de_b         (de_b),
      .commit_valid (commit_valid),
      .commit_reg   (commit_reg),
      .commit_data  (commit_data),
      .halted       (halted)
   );

endmodule

// File: verif/wisc_core_checker.sv
/* Checker for the pipeline core: queues expected commits per transfer,
   compares commit timing and values, instr_ready, halted and err */
`timescale 1ns/10ps

module wisc_core_checker (
   input  logic               clk,
   input  logic               rst,
   input  logic               instr_valid,
   input  logic               instr_ready,
   input  logic               commit_valid,
   input  wisc_pkg::reg_idx_t commit_reg,
   input  wisc_pkg::data_t    commit_data,
   input  logic               halted,
   input  logic               err,
   input  logic               exp_push,
   input  logic               exp_commit,
   input  logic               exp_illegal,
   input  logic               exp_halt,
   input  wisc_pkg::reg_idx_t exp_reg,
   input  wisc_pkg::data_t    exp_data,
   output int                 value_errors,
   output int                 protocol_errors,
   output int                 pending
);

   import wisc_pkg::*;

   localparam int LATENCY = 3;

   int       cyc = 0;
   int       due_q[$];
   reg_idx_t reg_q[$];
   data_t    data_q[$];
   int       err_from = -1;
   int       halted_from = -1;
   logic     halt_taken = 1'b0;

   initial begin
      value_errors    = 0;
      protocol_errors = 0;
      pending         = 0;
   end

   task automatic report_mismatch(string name, data_t expected, data_t actual);
      $display("Error at %0d ns: %s expected %0h got %0h", $time, name, expected, actual);
      value_errors = value_errors + 1;
   endtask

   task automatic report_problem(string msg);
      $display("At %0d ns: %s", $time, msg);
      protocol_errors = protocol_errors + 1;
   endtask

   // Also covers the state right after reset
   task automatic check_status();
      logic want_ready;
      logic want_halted;
      logic want_err;
      want_ready  = !halt_taken;
      want_halted = halt_taken && (cyc >= halted_from);
      want_err    = (err_from >= 0) && (cyc >= err_from);
      if (instr_ready !== want_ready) begin
         report_mismatch("instr_ready", data_t'(want_ready), data_t'(instr_ready));
      end
      if (halted !== want_halted) begin
         report_mismatch("halted", data_t'(want_halted), data_t'(halted));
      end
      if (err !== want_err) begin
         report_mismatch("err", data_t'(want_err), data_t'(err));
      end
   endtask

   task automatic check_commit();
      int       due;
      reg_idx_t want_reg;
      data_t    want_data;
      while (due_q.size() > 0 && due_q[0] < cyc) begin
         report_problem($sformatf("commit to r%0d due at cycle %0d never arrived",
                                  reg_q[0], due_q[0]));
         void'(due_q.pop_front());
         void'(reg_q.pop_front());
         void'(data_q.pop_front());
      end
      if (commit_valid === 1'b1) begin
         if (due_q.size() == 0) begin
            report_problem($sformatf("commit to r%0d with no instruction outstanding",
                                     commit_reg));
         end else begin
            due       = due_q.pop_front();
            want_reg  = reg_q.pop_front();
            want_data = data_q.pop_front();
            if (due != cyc) begin
               report_problem($sformatf("commit came %0d cycles after transfer, not %0d",
                                        LATENCY - (due - cyc), LATENCY));
            end
            if (commit_reg !== want_reg) begin
               report_mismatch("commit_reg", data_t'(want_reg), data_t'(commit_reg));
            end
            if (commit_data !== want_data) begin
               report_mismatch("commit_data", want_data, commit_data);
            end
         end
      end
   endtask

   task automatic record_transfer();
      if (instr_valid === 1'b1 && instr_ready === 1'b1) begin
         if (halt_taken) begin
            report_problem("instruction accepted after HALT");
         end
         if (exp_push !== 1'b1) begin
            report_problem("instruction transferred without an expectation from the driver");
         end else begin
            if (exp_commit) begin
               due_q.push_back(cyc + LATENCY);
               reg_q.push_back(exp_reg);
               data_q.push_back(exp_data);
            end
            if (exp_illegal && err_from < 0) begin
               err_from = cyc + 2;
            end
            if (exp_halt) begin
               halt_taken  = 1'b1;
               halted_from = cyc + LATENCY;
            end
         end
      end
   endtask

   always @(posedge clk) begin
      if (!rst) begin
         cyc = cyc + 1;
         check_status();
         check_commit();
         record_transfer();
         pending = due_q.size();
      end
   end

endmodule

// File: verif/wisc_core_tb.sv
/* Testbench top for the pipeline core: clock, reset, instruction table,
   randomized gaps between rows and the closing report */
`timescale 1ns/10ps

module wisc_core_tb;

   import wisc_pkg::*;

   localparam logic [4:0] BAD_OPCODE = 5'b00111;
   localparam int KIND_PLAIN   = 0;
   localparam int KIND_ILLEGAL = 1;
   localparam int KIND_HALT    = 2;

   logic     clk = 1'b0;
   logic     rst;
   logic     instr_valid;
   data_t    instr;
   logic     instr_ready;
   logic     commit_valid;
   reg_idx_t commit_reg;
   data_t    commit_data;
   logic     halted;
   logic     err;

   logic     exp_push;
   logic     exp_commit;
   logic     exp_illegal;
   logic     exp_halt;
   reg_idx_t exp_reg;
   data_t    exp_data;
   int       value_errors;
   int       protocol_errors;
   int       pending;

   // Stimulus table, one entry per instruction
   data_t    tab_instr[$];
   logic     tab_commit[$];
   reg_idx_t tab_reg[$];
   data_t    tab_data[$];
   int       tab_kind[$];

   logic [15:0] lfsr;
   int          cycles = 0;
   int          max_cycles;

   always #20 clk = ~clk;

   wisc_core wisc_core_i (
      .clk          (clk),
      .rst          (rst),
      .instr_valid  (instr_valid),
      .instr        (instr),
      .instr_ready  (instr_ready),
      .commit_valid (commit_valid),
      .commit_reg   (commit_reg),
      .commit_data  (commit_data),
      .halted       (halted),
      .err          (err)
   );

   wisc_core_checker checker_i (
      .clk             (clk),
      .rst             (rst),
      .instr_valid     (instr_valid),
      .instr_ready     (instr_ready),
      .commit_valid    (commit_valid),
      .commit_reg      (commit_reg),
      .commit_data     (commit_data),
      .halted          (halted),
      .err             (err),
      .exp_push        (exp_push),
      .exp_commit      (exp_commit),
      .exp_illegal     (exp_illegal),
      .exp_halt        (exp_halt),
      .exp_reg         (exp_reg),
      .exp_data        (exp_data),
      .value_errors    (value_errors),
      .protocol_errors (protocol_errors),
      .pending         (pending)
   );

   function automatic data_t rr_instr(rfunc_t fn, reg_idx_t rs, reg_idx_t rt, reg_idx_t rd);
      return {OP_RTYPE, rs, rt, rd, fn};
   endfunction

   function automatic data_t imm_instr(opcode_t op, reg_idx_t rs, reg_idx_t rd,
                                       logic [4:0] imm5);
      return {op, rs, rd, imm5};
   endfunction

   function automatic data_t byte_instr(opcode_t op, reg_idx_t rs, logic [7:0] imm8);
      return {op, rs, imm8};
   endfunction

   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      if (s[0]) begin
         return (s >> 1) ^ 16'hB400;
      end
      return s >> 1;
   endfunction

   // Two LFSR bits give an idle gap of 0 to 3 cycles
   task automatic draw_gap(output int gap);
      gap = 0;
      for (int b = 0; b < 2; b++) begin
         gap = gap | (int'(lfsr[0]) << b);
         lfsr = lfsr_next(lfsr);
      end
   endtask

   task automatic add_row(data_t word, logic commits, reg_idx_t rd, data_t value, int kind);
      tab_instr.push_back(word);
      tab_commit.push_back(commits);
      tab_reg.push_back(rd);
      tab_data.push_back(value);
      tab_kind.push_back(kind);
   endtask

   // Expected values follow the ISA rules, registers start at zero
   task automatic fill_table();
      add_row(byte_instr(OP_LBI, 1, 8'h12), 1'b1, 1, 16'h0012, KIND_PLAIN);
      add_row(byte_instr(OP_SLBI, 1, 8'h34), 1'b1, 1, 16'h1234, KIND_PLAIN);
      add_row(byte_instr(OP_LBI, 2, 8'hF0), 1'b1, 2, 16'hFFF0, KIND_PLAIN);
      add_row(byte_instr(OP_SLBI, 2, 8'h0F), 1'b1, 2, 16'hF00F, KIND_PLAIN);
      // ADD carries out of bit 15
      add_row(rr_instr(FN_ADD, 1, 2, 3), 1'b1, 3, 16'h0243, KIND_PLAIN);
      // SUB is Rt minus Rs, r1 - r3
      add_row(rr_instr(FN_SUB, 3, 1, 4), 1'b1, 4, 16'h0FF1, KIND_PLAIN);
      add_row(rr_instr(FN_XOR, 4, 3, 5), 1'b1, 5, 16'h0DB2, KIND_PLAIN);
      add_row(rr_instr(FN_ANDN, 2, 5, 6), 1'b1, 6, 16'hF00D, KIND_PLAIN);
      add_row(imm_instr(OP_ADDI, 6, 7, 5'b11111), 1'b1, 7, 16'hF00C, KIND_PLAIN);
      // 3 - 0xF00C wraps
      add_row(imm_instr(OP_SUBI, 7, 0, 5'd3), 1'b1, 0, 16'h0FF7, KIND_PLAIN);
      add_row(imm_instr(OP_XORI, 0, 1, 5'b10101), 1'b1, 1, 16'hF002, KIND_PLAIN);
      add_row(imm_instr(OP_ANDNI, 1, 2, 5'd2), 1'b1, 2, 16'hF000, KIND_PLAIN);
      add_row(byte_instr(OP_NOP, 0, 8'h00), 1'b0, 0, 16'h0000, KIND_PLAIN);
      add_row({BAD_OPCODE, 11'h0E5}, 1'b0, 0, 16'h0000, KIND_ILLEGAL);
      add_row(byte_instr(OP_LBI, 3, 8'hFF), 1'b1, 3, 16'hFFFF, KIND_PLAIN);
      add_row(imm_instr(OP_ADDI, 3, 4, 5'd1), 1'b1, 4, 16'h0000, KIND_PLAIN);
      add_row(rr_instr(FN_SUB, 3, 4, 5), 1'b1, 5, 16'h0001, KIND_PLAIN);
      add_row(rr_instr(FN_ADD, 5, 5, 6), 1'b1, 6, 16'h0002, KIND_PLAIN);
      add_row(rr_instr(FN_XOR, 6, 5, 7), 1'b1, 7, 16'h0003, KIND_PLAIN);
      // r7 on Rt, straight behind its producer
      add_row(rr_instr(FN_ADD, 1, 7, 0), 1'b1, 0, 16'hF005, KIND_PLAIN);
      add_row(byte_instr(OP_HALT, 0, 8'h00), 1'b0, 0, 16'h0000, KIND_HALT);
   endtask

   task automatic offer_row(int i);
      instr_valid = 1'b1;
      instr       = tab_instr[i];
      exp_push    = 1'b1;
      exp_commit  = tab_commit[i];
      exp_reg     = tab_reg[i];
      exp_data    = tab_data[i];
      exp_illegal = (tab_kind[i] == KIND_ILLEGAL);
      exp_halt    = (tab_kind[i] == KIND_HALT);
   endtask

   initial begin
      int gap;
      rst         = 1'b1;
      instr_valid = 1'b0;
      instr       = '0;
      exp_push    = 1'b0;
      exp_commit  = 1'b0;
      exp_illegal = 1'b0;
      exp_halt    = 1'b0;
      exp_reg     = '0;
      exp_data    = '0;
      lfsr        = 16'd22094;
      fill_table();
      max_cycles = tab_instr.size() * 4 + 20;

      repeat (3) @(negedge clk);
      rst = 1'b0;

      for (int i = 0; i < tab_instr.size(); i++) begin
         instr_valid = 1'b0;
         exp_push    = 1'b0;
         draw_gap(gap);
         repeat (gap) @(negedge clk);
         offer_row(i);
         // Ready only moves on the rising edge
         while (instr_ready !== 1'b1) begin
            @(negedge clk);
         end
         @(negedge clk);
      end

      // Offered after HALT, must never be taken
      instr_valid = 1'b1;
      instr       = imm_instr(OP_ADDI, 0, 1, 5'd1);
      exp_push    = 1'b1;
      exp_commit  = 1'b1;
      exp_illegal = 1'b0;
      exp_halt    = 1'b0;
      exp_reg     = 1;
      exp_data    = 16'hF006;

      while (!(halted === 1'b1 && pending == 0)) begin
         @(negedge clk);
      end
      repeat (4) @(negedge clk);
      instr_valid = 1'b0;
      exp_push    = 1'b0;
      @(negedge clk);

      $display("value errors: %0d, protocol errors: %0d", value_errors, protocol_errors);
      if (value_errors + protocol_errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

   always @(posedge clk) begin
      cycles = cycles + 1;
      if (cycles >= max_cycles) begin
         $display("Timeout: run stopped after %0d cycles without reaching the end", cycles);
         $display("test failed");
         $finish;
      end
   end

endmodule

// File: wisc_core.f
hw/wisc_pkg.sv
hw/fetch.sv
hw/reg_file.sv
hw/decode.sv
hw/execute.sv
hw/wisc_core.sv
verif/wisc_core_checker.sv
verif/wisc_core_tb.sv

// File: Bender.yml
package:
  name: wisc_core

sources:
  - hw/wisc_pkg.sv
  - hw/fetch.sv
  - hw/reg_file.sv
  - hw/decode.sv
  - hw/execute.sv
  - hw/wisc_core.sv
  - target: simulation
    files:
      - verif/wisc_core_checker.sv
      - verif/wisc_core_tb.sv
